// File: bench/dcache_checker.sv
module dcache_checker
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              req_valid,
	input  cache_pkg::cpu_op_t                req_op,
	input  logic [mem_bus_pkg::addr_bits-1:0] req_addr,
	input  logic [mem_bus_pkg::data_bits-1:0] req_wdata,
	input  logic                              req_ready,
	input  logic                              resp_valid,
	input  logic [mem_bus_pkg::data_bits-1:0] resp_rdata,
	input  logic                              halt,
	input  logic                              halt_done,
	input  logic                              mem_valid,
	input  mem_bus_pkg::mem_cmd_t             mem_cmd,
	input  logic [mem_bus_pkg::addr_bits-1:0] mem_addr,
	input  logic [mem_bus_pkg::data_bits-1:0] mem_wdata,
	input  logic                              mem_ready,
	input  logic                              report_now,
	input  int                                timeout_count,
	output int                                error_count
);

	logic [mem_bus_pkg::data_bits-1:0] ref_image [1024];
	logic [mem_bus_pkg::data_bits-1:0] bus_image [1024]; // Memory as seen on the bus.
	logic                              touched [1024];
	logic                              outstanding;
	logic                              expect_load;
	logic [mem_bus_pkg::data_bits-1:0] expect_data;
	logic                              halt_seen;
	logic                              flush_checked;
	logic                              stalled;
	logic [mem_bus_pkg::addr_bits-1:0] held_addr;
	logic [mem_bus_pkg::data_bits-1:0] held_wdata;
	mem_bus_pkg::mem_cmd_t             held_cmd;
	int                                halt_count;
	int                                check_count;

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		if (expected != actual)
		begin
			error_count++;
			$display("MISMATCH %s expected %h actual %h at time %0t", name, expected, actual,
				$time);
		end
	endtask

	task automatic report_error(input string what);
		error_count++;
		$display("ERROR: %s at time %0t", what, $time);
	endtask

	always @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < 1024; i++)
			begin
				ref_image[i] = '0;
				bus_image[i] = '0;
				touched[i] = 1'b0;
			end
			outstanding = 1'b0;
			halt_seen = 1'b0;
			flush_checked = 1'b0;
			stalled = 1'b0;
			halt_count = 0;
			check_count = 0;
			error_count = 0;
		end
		else
		begin
			if (halt && !halt_seen)
			begin
				halt_count++;
				flush_checked = 1'b0;
			end
			halt_seen = halt;

			if (stalled && (!mem_valid || (mem_addr != held_addr) || (mem_wdata != held_wdata)
				|| (mem_cmd != held_cmd)))
				report_error("memory request changed while mem_ready was low");
			stalled = mem_valid && !mem_ready;
			held_addr = mem_addr;
			held_wdata = mem_wdata;
			held_cmd = mem_cmd;

			if (mem_valid && mem_ready && (mem_cmd == mem_bus_pkg::cmd_store))
			begin
				check_value("evict_data", ref_image[mem_addr[12:3]], mem_wdata);
				bus_image[mem_addr[12:3]] = mem_wdata;
				if ((halt_count == 2) && halt)
					report_error("memory store during the second halt");
			end

			if (resp_valid)
			begin
				if (!outstanding)
					report_error("response arrived with no request outstanding");
				else if (expect_load)
					check_value("load_data", expect_data, resp_rdata);
				outstanding = 1'b0;
			end

			if (req_valid && req_ready)
			begin
				if (outstanding)
					report_error("request accepted while another was outstanding");
				outstanding = 1'b1;
				expect_load = (req_op == cache_pkg::op_load);
				expect_data = ref_image[req_addr[12:3]];
				if (!expect_load)
				begin
					ref_image[req_addr[12:3]] = req_wdata;
					touched[req_addr[12:3]] = 1'b1;
				end
			end

			// Dirty lines must all be in memory once halt completes.
			if (halt && halt_done && !flush_checked)
			begin
				flush_checked = 1'b1;
				for (int i = 0; i < 1024; i++)
					if (touched[i])
						check_value("flush_image", ref_image[i], bus_image[i]);
			end
		end
	end

	always @(posedge report_now)
		$display("Checker summary: %0d checks, %0d errors, %0d timeouts", check_count,
			error_count, timeout_count);

endmodule

// File: bench/dcache_tb.sv
module dcache_tb;

	localparam int timeout_cycles = 200;
	localparam int request_count = 400;
	localparam int wait_accept = 0;
	localparam int wait_resp = 1;
	localparam int wait_halt = 2;

	logic                              clock = 1'b0;
	logic                              reset;
	logic                              req_valid;
	cache_pkg::cpu_op_t                req_op;
	logic [mem_bus_pkg::addr_bits-1:0] req_addr;
	logic [mem_bus_pkg::data_bits-1:0] req_wdata;
	logic                              req_ready;
	logic                              resp_valid;
	logic [mem_bus_pkg::data_bits-1:0] resp_rdata;
	logic                              halt;
	logic                              halt_done;
	logic                              mem_valid;
	mem_bus_pkg::mem_cmd_t             mem_cmd;
	logic [mem_bus_pkg::addr_bits-1:0] mem_addr;
	logic [mem_bus_pkg::data_bits-1:0] mem_wdata;
	logic                              mem_ready = 1'b0;
	logic                              mem_rvalid = 1'b0;
	logic [mem_bus_pkg::data_bits-1:0] mem_rdata = '0;
	logic [mem_bus_pkg::data_bits-1:0] backing [1024];
	logic                              xfer_load = 1'b0;
	logic [9:0]                        xfer_slot;
	logic                              next_ready = 1'b0;
	logic [2:0]                        next_delay;
	logic                              load_busy = 1'b0;
	logic [2:0]                        load_delay;
	logic [9:0]                        load_slot;
	logic [31:0]                       mem_rnd;
	logic                              report_now;
	logic                              timed_out;
	int                                timeout_count;
	int                                error_count;
	int                                seed;

	dcache_subsystem dut (.*);

	dcache_checker check (.*);

	initial
	begin
		forever #5 clock = ~clock;
	end

	// Memory responder takes bus transfers on the rising edge.
	always @(posedge clock)
	begin
		mem_rnd = $random(seed);
		next_ready = (mem_rnd[1:0] != 2'b00);
		next_delay = {1'b0, mem_rnd[3:2]} + 3'd1; // 1 to 4 cycles.
		xfer_load = 1'b0;
		if (reset)
		begin
			for (int i = 0; i < 1024; i++)
				backing[i] = '0;
		end
		else if (mem_valid && mem_ready)
		begin
			if (mem_cmd == mem_bus_pkg::cmd_store)
				backing[mem_addr[12:3]] = mem_wdata;
			else
			begin
				xfer_load = 1'b1;
				xfer_slot = mem_addr[12:3];
			end
		end
	end

	always @(negedge clock)
	begin
		mem_ready = next_ready;
		mem_rvalid = 1'b0;
		if (reset)
			load_busy = 1'b0;
		else if (xfer_load)
		begin
			load_busy = 1'b1;
			load_delay = next_delay;
			load_slot = xfer_slot;
		end
		else if (load_busy)
		begin
			load_delay = load_delay - 3'd1;
			if (load_delay == 3'd0)
			begin
				load_busy = 1'b0;
				mem_rvalid = 1'b1;
				mem_rdata = backing[load_slot];
			end
		end
	end

	task automatic report_stall(input string what);
		$display("TIMEOUT: no %s within %0d cycles", what, timeout_cycles);
		timeout_count++;
		timed_out = 1'b1;
	endtask

	task automatic wait_for(input int which, input string what);
		int   waited;
		logic seen;
		waited = 0;
		seen = 1'b0;
		while (!seen && !timed_out)
		begin
			@(posedge clock);
			case (which)
				wait_accept: seen = req_ready;
				wait_resp: seen = resp_valid;
				default: seen = halt_done;
			endcase
			if (!seen)
			begin
				waited++;
				if (waited >= timeout_cycles)
					report_stall(what);
			end
		end
	endtask

	task automatic send_random_request;
		logic [31:0] rnd;
		logic [6:0]  idx;
		@(negedge clock);
		rnd = $random(seed);
		idx = {4'd0, rnd[2:0]} * 7'd9; // Eight indexes, eight tags each.
		if (rnd[9])
			req_op = cache_pkg::op_store;
		else
			req_op = cache_pkg::op_load;
		req_addr = {19'd0, rnd[5:3], idx, rnd[8:6]};
		rnd = $random(seed);
		req_wdata[31:0] = rnd;
		rnd = $random(seed);
		req_wdata[63:32] = rnd;
		req_valid = 1'b1;
		wait_for(wait_accept, "acceptance of a processor request");
		@(negedge clock);
		req_valid = 1'b0;
		wait_for(wait_resp, "resp_valid for an accepted request");
	endtask

	task automatic run_halt;
		@(negedge clock);
		halt = 1'b1;
		wait_for(wait_halt, "halt_done after raising halt");
		@(negedge clock);
		halt = 1'b0;
		repeat (2) @(negedge clock);
	endtask

	task automatic finish_run;
		@(negedge clock);
		report_now = 1'b1;
		#1;
		if ((error_count == 0) && (timeout_count == 0))
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	initial
	begin
		seed = 32'hbb307ec7;
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = cache_pkg::op_load;
		req_addr = '0;
		req_wdata = '0;
		halt = 1'b0;
		report_now = 1'b0;
		timed_out = 1'b0;
		timeout_count = 0;
		repeat (3) @(negedge clock);
		reset = 1'b0;
		for (int n = 0; (n < request_count) && !timed_out; n++)
			send_random_request();
		if (!timed_out)
			run_halt();
		if (!timed_out)
			run_halt(); // Nothing dirty left.
		finish_run();
	end

endmodule

// File: design/cache_pkg.sv
package cache_pkg;

	localparam int line_count = 128;
	localparam int index_bits = 7;
	localparam int tag_bits = 22;
	localparam int offset_bits = 3; // Byte offset inside a word.

	typedef enum logic
	{
		op_load = 1'b0,
		op_store = 1'b1
	} cpu_op_t;

endpackage

// File: design/dcache_ctrl.sv
module dcache_ctrl
(
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic                                 req_valid,
	input  cache_pkg::cpu_op_t                   req_op,
	input  logic [mem_bus_pkg::addr_bits-1:0]    req_addr,
	input  logic [mem_bus_pkg::data_bits-1:0]    req_wdata,
	output logic                                 req_ready,
	output logic                                 resp_valid,
	output logic [mem_bus_pkg::data_bits-1:0]    resp_rdata,
	input  logic                                 halt,
	output logic [cache_pkg::index_bits-1:0]     lookup_idx,
	output logic [cache_pkg::tag_bits-1:0]       lookup_tag,
	input  logic                                 hit,
	input  logic [mem_bus_pkg::data_bits-1:0]    line_data,
	input  logic                                 victim_dirty,
	input  logic [cache_pkg::tag_bits-1:0]       victim_tag,
	output logic                                 store_en,
	output logic [cache_pkg::index_bits-1:0]     store_idx,
	output logic [cache_pkg::tag_bits-1:0]       store_tag,
	output logic [mem_bus_pkg::data_bits-1:0]    store_data,
	output logic                                 fill_en,
	output logic [cache_pkg::index_bits-1:0]     fill_idx,
	output logic [cache_pkg::tag_bits-1:0]       fill_tag,
	output logic [mem_bus_pkg::data_bits-1:0]    fill_data,
	output logic                                 ctrl_valid,
	output mem_bus_pkg::mem_cmd_t                ctrl_cmd,
	output logic [mem_bus_pkg::addr_bits-1:0]    ctrl_addr,
	output logic [mem_bus_pkg::data_bits-1:0]    ctrl_wdata,
	input  logic                                 ctrl_ready,
	input  logic                                 ctrl_rvalid,
	input  logic [mem_bus_pkg::data_bits-1:0]    ctrl_rdata
);

	typedef enum logic [2:0]
	{
		st_idle,
		st_lookup,
		st_evict,
		st_fill_req,
		st_fill_wait,
		st_respond
	} state_t;

	state_t                            state;
	state_t                            state_next;
	cache_pkg::cpu_op_t                req_op_r;
	logic [cache_pkg::tag_bits-1:0]    req_tag_r;
	logic [cache_pkg::index_bits-1:0]  req_idx_r;
	logic [mem_bus_pkg::data_bits-1:0] req_wdata_r;
	logic                              accept;
	logic                              fill_done;
	logic                              is_store;

	assign req_ready = (state == st_idle) && !halt;
	assign accept    = req_valid && req_ready;
	assign fill_done = (state == st_fill_wait) && ctrl_rvalid;
	assign is_store  = (req_op_r == cache_pkg::op_store);

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
				if (accept)
					state_next = st_lookup;
			st_lookup:
				if (hit)
					state_next = st_respond;
				else if (victim_dirty)
					state_next = st_evict;
				else
					state_next = st_fill_req;
			st_evict:
				if (ctrl_ready)
					state_next = st_fill_req;
			st_fill_req:
				if (ctrl_ready)
					state_next = st_fill_wait;
			st_fill_wait:
				if (ctrl_rvalid)
					state_next = st_respond;
			st_respond:
				state_next = st_idle;
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			req_op_r <= req_op;
			req_tag_r <= req_addr[mem_bus_pkg::addr_bits-1 -: cache_pkg::tag_bits];
			req_idx_r <= req_addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
			req_wdata_r <= req_wdata;
		end
		if ((state == st_lookup) && hit)
			resp_rdata <= line_data;
		else if (fill_done)
			resp_rdata <= ctrl_rdata;
	end

	assign resp_valid = (state == st_respond);

	assign lookup_idx = req_idx_r;
	assign lookup_tag = req_tag_r;

	// A store miss writes over the fill in the same cycle.
	assign store_en   = is_store && (((state == st_lookup) && hit) || fill_done);
	assign store_idx  = req_idx_r;
	assign store_tag  = req_tag_r;
	assign store_data = req_wdata_r;

	assign fill_en   = fill_done;
	assign fill_idx  = req_idx_r;
	assign fill_tag  = req_tag_r;
	assign fill_data = ctrl_rdata;

	assign ctrl_valid = (state == st_evict) || (state == st_fill_req);
	assign ctrl_cmd   = (state == st_evict) ? mem_bus_pkg::cmd_store : mem_bus_pkg::cmd_load;
	assign ctrl_addr  = (state == st_evict)
		? {victim_tag, req_idx_r, {cache_pkg::offset_bits{1'b0}}}
		: {req_tag_r, req_idx_r, {cache_pkg::offset_bits{1'b0}}};
	assign ctrl_wdata = line_data; // Victim word.

	// Halt only comes with no request in flight.
	a_halt_only_idle: assert property (@(posedge clock) disable iff (reset)
		halt |-> (state == st_idle));

endmodule

// File: design/dcache_mem.sv
module dcache_mem
(
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic [cache_pkg::index_bits-1:0]     lookup_idx,
	input  logic [cache_pkg::tag_bits-1:0]       lookup_tag,
	output logic                                 hit,
	output logic [mem_bus_pkg::data_bits-1:0]    line_data,
	output logic                                 victim_dirty,
	output logic [cache_pkg::tag_bits-1:0]       victim_tag,
	input  logic                                 store_en,
	input  logic [cache_pkg::index_bits-1:0]     store_idx,
	input  logic [cache_pkg::tag_bits-1:0]       store_tag,
	input  logic [mem_bus_pkg::data_bits-1:0]    store_data,
	input  logic                                 fill_en,
	input  logic [cache_pkg::index_bits-1:0]     fill_idx,
	input  logic [cache_pkg::tag_bits-1:0]       fill_tag,
	input  logic [mem_bus_pkg::data_bits-1:0]    fill_data,
	input  logic                                 halt,
	output logic                                 flush_valid,
	output logic [mem_bus_pkg::addr_bits-1:0]    flush_addr,
	output logic [mem_bus_pkg::data_bits-1:0]    flush_wdata,
	input  logic                                 flush_ready,
	output logic                                 halt_done
);

	logic [mem_bus_pkg::data_bits-1:0] data_array [cache_pkg::line_count];
	logic [cache_pkg::tag_bits-1:0]    tag_array  [cache_pkg::line_count];
	logic [cache_pkg::line_count-1:0]  valid_bits;
	logic [cache_pkg::line_count-1:0]  dirty_bits;
	logic                              flush_found;
	logic [cache_pkg::index_bits-1:0]  flush_idx;
	logic                              fill_blocked;

	assign hit          = valid_bits[lookup_idx] && (tag_array[lookup_idx] == lookup_tag);
	assign line_data    = data_array[lookup_idx];
	assign victim_dirty = valid_bits[lookup_idx] && dirty_bits[lookup_idx];
	assign victim_tag   = tag_array[lookup_idx];

	assign fill_blocked = store_en && (store_idx == fill_idx); // Store wins.

	// Downward loop so the last match is the lowest dirty line.
	always_comb
	begin
		flush_found = 1'b0;
		flush_idx = '0;
		for (int i = cache_pkg::line_count - 1; i >= 0; i--)
		begin
			if (valid_bits[i] && dirty_bits[i])
			begin
				flush_found = 1'b1;
				flush_idx = cache_pkg::index_bits'(i);
			end
		end
	end

	assign flush_valid = halt && flush_found;
	assign flush_addr  = {tag_array[flush_idx], flush_idx, {cache_pkg::offset_bits{1'b0}}};
	assign flush_wdata = data_array[flush_idx];
	assign halt_done   = halt && !flush_found;

	always_ff @(posedge clock)
	begin
		if (fill_en && !fill_blocked)
		begin
			data_array[fill_idx] <= fill_data;
			tag_array[fill_idx] <= fill_tag;
		end
		if (store_en)
		begin
			data_array[store_idx] <= store_data;
			tag_array[store_idx] <= store_tag;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else
		begin
			if (flush_valid && flush_ready)
				dirty_bits[flush_idx] <= 1'b0; // Line now clean in memory.
			if (fill_en && !fill_blocked)
			begin
				valid_bits[fill_idx] <= 1'b1;
				dirty_bits[fill_idx] <= 1'b0;
			end
			if (store_en)
			begin
				valid_bits[store_idx] <= 1'b1;
				dirty_bits[store_idx] <= 1'b1;
			end
		end
	end

	// Controller stays idle during a halt.
	a_no_write_clash_in_halt: assert property (@(posedge clock) disable iff (reset)
		halt |-> !(store_en && fill_en && (store_idx == fill_idx)));

	a_flush_held_when_stalled: assert property (@(posedge clock) disable iff (reset)
		flush_valid && !flush_ready |=> !halt
			|| (flush_valid && $stable(flush_addr) && $stable(flush_wdata)));

endmodule

// File: design/dcache_subsystem.sv
module dcache_subsystem
(
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic                                 req_valid,
	input  cache_pkg::cpu_op_t                   req_op,
	input  logic [mem_bus_pkg::addr_bits-1:0]    req_addr,
	input  logic [mem_bus_pkg::data_bits-1:0]    req_wdata,
	output logic                                 req_ready,
	output logic                                 resp_valid,
	output logic [mem_bus_pkg::data_bits-1:0]    resp_rdata,
	input  logic                                 halt,
	output logic                                 halt_done,
	output logic                                 mem_valid,
	output mem_bus_pkg::mem_cmd_t                mem_cmd,
	output logic [mem_bus_pkg::addr_bits-1:0]    mem_addr,
	output logic [mem_bus_pkg::data_bits-1:0]    mem_wdata,
	input  logic                                 mem_ready,
	input  logic                                 mem_rvalid,
	input  logic [mem_bus_pkg::data_bits-1:0]    mem_rdata
);

	logic [cache_pkg::index_bits-1:0]  lookup_idx;
	logic [cache_pkg::tag_bits-1:0]    lookup_tag;
	logic                              hit;
	logic [mem_bus_pkg::data_bits-1:0] line_data;
	logic                              victim_dirty;
	logic [cache_pkg::tag_bits-1:0]    victim_tag;
	logic                              store_en;
	logic [cache_pkg::index_bits-1:0]  store_idx;
	logic [cache_pkg::tag_bits-1:0]    store_tag;
	logic [mem_bus_pkg::data_bits-1:0] store_data;
	logic                              fill_en;
	logic [cache_pkg::index_bits-1:0]  fill_idx;
	logic [cache_pkg::tag_bits-1:0]    fill_tag;
	logic [mem_bus_pkg::data_bits-1:0] fill_data;
	logic                              ctrl_valid;
	mem_bus_pkg::mem_cmd_t             ctrl_cmd;
	logic [mem_bus_pkg::addr_bits-1:0] ctrl_addr;
	logic [mem_bus_pkg::data_bits-1:0] ctrl_wdata;
	logic                              ctrl_ready;
	logic                              ctrl_rvalid;
	logic [mem_bus_pkg::data_bits-1:0] ctrl_rdata;
	logic                              flush_valid;
	logic [mem_bus_pkg::addr_bits-1:0] flush_addr;
	logic [mem_bus_pkg::data_bits-1:0] flush_wdata;
	logic                              flush_ready;

	dcache_mem u_mem (.*);

	dcache_ctrl u_ctrl (.*);

	mem_arbiter u_arbiter (.*);

endmodule

// File: design/mem_arbiter.sv
module mem_arbiter
(
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic                                 ctrl_valid,
	input  mem_bus_pkg::mem_cmd_t                ctrl_cmd,
	input  logic [mem_bus_pkg::addr_bits-1:0]    ctrl_addr,
	input  logic [mem_bus_pkg::data_bits-1:0]    ctrl_wdata,
	output logic                                 ctrl_ready,
	output logic                                 ctrl_rvalid,
	output logic [mem_bus_pkg::data_bits-1:0]    ctrl_rdata,
	input  logic                                 flush_valid,
	input  logic [mem_bus_pkg::addr_bits-1:0]    flush_addr,
	input  logic [mem_bus_pkg::data_bits-1:0]    flush_wdata,
	output logic                                 flush_ready,
	output logic                                 mem_valid,
	output mem_bus_pkg::mem_cmd_t                mem_cmd,
	output logic [mem_bus_pkg::addr_bits-1:0]    mem_addr,
	output logic [mem_bus_pkg::data_bits-1:0]    mem_wdata,
	input  logic                                 mem_ready,
	input  logic                                 mem_rvalid,
	input  logic [mem_bus_pkg::data_bits-1:0]    mem_rdata
);

	logic load_pending;
	logic grant_ctrl;
	logic grant_flush;

	assign grant_ctrl  = !load_pending && ctrl_valid; // Controller first.
	assign grant_flush = !load_pending && !ctrl_valid && flush_valid;

	assign mem_valid = grant_ctrl || grant_flush;
	assign mem_cmd   = grant_ctrl ? ctrl_cmd : mem_bus_pkg::cmd_store;
	assign mem_addr  = grant_ctrl ? ctrl_addr : flush_addr;
	assign mem_wdata = grant_ctrl ? ctrl_wdata : flush_wdata;

	assign ctrl_ready  = grant_ctrl && mem_ready;
	assign flush_ready = grant_flush && mem_ready;

	assign ctrl_rvalid = mem_rvalid;
	assign ctrl_rdata  = mem_rdata;

	always_ff @(posedge clock)
	begin
		if (reset)
			load_pending <= 1'b0;
		else if (ctrl_ready && (ctrl_cmd == mem_bus_pkg::cmd_load))
			load_pending <= 1'b1;
		else if (mem_rvalid)
			load_pending <= 1'b0;
	end

	a_rvalid_needs_load: assert property (@(posedge clock) disable iff (reset)
		mem_rvalid |-> load_pending);

endmodule

// File: design/mem_bus_pkg.sv
package mem_bus_pkg;

	localparam int addr_bits = 32; // Byte address.
	localparam int data_bits = 64;

	typedef enum logic
	{
		cmd_load = 1'b0,
		cmd_store = 1'b1
	} mem_cmd_t;

endpackage

// File: files.f
design/cache_pkg.sv
design/mem_bus_pkg.sv
design/dcache_mem.sv
design/dcache_ctrl.sv
design/mem_arbiter.sv
design/dcache_subsystem.sv
bench/dcache_checker.sv
bench/dcache_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^All tests passed$" sim.log; then
	exit 0
fi
exit 1
